// File: include/udp_stream_cfg.svh
`ifndef UDP_STREAM_CFG_SVH
`define UDP_STREAM_CFG_SVH

// Frame geometry
`define UDP_PAYLOAD_HALFWORDS 16
`define UDP_FRAME_BYTES (42 + 2 * `UDP_PAYLOAD_HALFWORDS)
`define UDP_BEATS ((`UDP_FRAME_BYTES + 7) / 8)

// Stream and register widths
`define UDP_DATA_W 64
`define UDP_KEEP_W 8
`define UDP_REG_ADDR_W 6
`define UDP_REG_W 32

// Register map
`define UDP_ADDR_SENT 6'h00
`define UDP_ADDR_STATUS 6'h04
`define UDP_ADDR_DELAY 6'h08
`define UDP_ADDR_DMAC_LO 6'h0C
`define UDP_ADDR_DMAC_HI 6'h10
`define UDP_ADDR_SIP 6'h14
`define UDP_ADDR_DIP 6'h18
`define UDP_ADDR_SPORT 6'h1C
`define UDP_ADDR_DPORT 6'h20

// Power-up header contents
`define UDP_DEFAULT_DELAY 32'd10000000
`define UDP_SRC_MAC 48'h001A_2B3C_4D5E
`define UDP_DEFAULT_SIP 32'hC0A8_0463 // 192.168.4.99
`define UDP_DEFAULT_DIP 32'hC0A8_0401 // 192.168.4.1
`define UDP_DEFAULT_PORT 16'd60133

`endif

// File: list.f
+incdir+include
source/udp_stream_pkg.sv
source/udp_regs.sv
source/ip_checksum.sv
source/send_timer.sv
source/frame_sender.sv
source/udp_stream_top.sv
test/udp_stream_checker.sv
test/udp_stream_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build with Verilator, run, and look for the pass line in the output
set -u
cd "$(dirname "$0")"

if ! verilator --binary --timing --assert -Wno-fatal -f list.f \
        --top-module udp_stream_tb -o sim_udp_stream; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/sim_udp_stream +verilator+error+limit+1000)"
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
if echo "$output" | grep -qx "test passed"; then
    exit 0
fi
exit 1

// File: source/frame_sender.sv
`timescale 1ns/1ps
`default_nettype none

`include "udp_stream_cfg.svh"

module frame_sender (
    input  logic                       m00_axis_aclk,
    input  logic                       s00_axi_aresetn,
    input  logic                       send_trigger,
    input  logic                       csum_ready,
    input  udp_stream_pkg::hdr_cfg_t   hdr_cfg,
    input  logic [15:0]                csum,
    input  logic                       tready,
    output udp_stream_pkg::axis_beat_t stream,
    output logic                       tvalid,
    output logic                       busy,
    output logic [31:0]                sent_count
);

    import udp_stream_pkg::*;

    localparam int HDR_BYTES = 42;
    localparam int BEAT_W = $clog2(`UDP_BEATS);
    localparam int LAST_BYTES = `UDP_FRAME_BYTES - 8 * (`UDP_BEATS - 1);
    localparam logic [BEAT_W-1:0] LAST_IDX = BEAT_W'(`UDP_BEATS - 1);
    localparam logic [`UDP_KEEP_W-1:0] LAST_KEEP = ~({`UDP_KEEP_W{1'b1}} << LAST_BYTES);
    localparam logic [15:0] IP_LEN = 16'(28 + 2 * `UDP_PAYLOAD_HALFWORDS);
    localparam logic [15:0] UDP_LEN = 16'(8 + 2 * `UDP_PAYLOAD_HALFWORDS);

    logic active;
    logic start;
    logic last_beat;
    logic [BEAT_W-1:0] beat_idx;
    hdr_cfg_t hdr_q;   // Header frozen for the frame in flight
    logic [15:0] csum_q;
    logic [HDR_BYTES*8-1:0] hdr_vec;
    logic [`UDP_BEATS-1:0][`UDP_KEEP_W-1:0][7:0] frame;

    assign start = !active && send_trigger && csum_ready; // Otherwise the trigger is lost
    assign last_beat = (beat_idx == LAST_IDX);
    assign tvalid = active;
    assign busy = active;

    // Ethernet, IPv4 and UDP headers with the first byte on top
    assign hdr_vec = {hdr_q.dst_mac, `UDP_SRC_MAC, 16'h0800,
                      16'h4500, IP_LEN, 16'h0001, 16'h4000, 16'hFF11, csum_q,
                      hdr_q.src_ip, hdr_q.dst_ip,
                      hdr_q.src_port, hdr_q.dst_port, UDP_LEN, 16'h0000};

    always_comb begin
        logic [15:0] ph;
        frame = '0;
        for (int i = 0; i < HDR_BYTES; i++) begin
            frame[i / 8][i % 8] = hdr_vec[(HDR_BYTES - 1 - i) * 8 +: 8];
        end
        for (int j = 0; j < `UDP_PAYLOAD_HALFWORDS; j++) begin
            ph = payload_half(j);
            frame[(HDR_BYTES + 2 * j) / 8][(HDR_BYTES + 2 * j) % 8] = ph[7:0]; // Low byte first
            frame[(HDR_BYTES + 2 * j + 1) / 8][(HDR_BYTES + 2 * j + 1) % 8] = ph[15:8];
        end
    end

    always_comb begin
        stream.tdata = frame[beat_idx];
        stream.tkeep = last_beat ? LAST_KEEP : '1;
        stream.tlast = last_beat;
    end

    always_ff @(posedge m00_axis_aclk or negedge s00_axi_aresetn) begin
        if (!s00_axi_aresetn) begin
            active     <= 1'b0;
            beat_idx   <= '0;
            sent_count <= 32'd0;
        end else if (start) begin
            active   <= 1'b1;
            beat_idx <= '0;
        end else if (active && tready) begin
            if (beat_idx == '0) sent_count <= sent_count + 32'd1; // Counted on first beat
            if (last_beat) begin
                active   <= 1'b0;
                beat_idx <= '0;
            end else begin
                beat_idx <= beat_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge m00_axis_aclk) begin
        if (start) begin
            hdr_q  <= hdr_cfg;
            csum_q <= csum;
        end
    end

endmodule

`default_nettype wire

// File: source/ip_checksum.sv
`timescale 1ns/1ps
`default_nettype none

`include "udp_stream_cfg.svh"

module ip_checksum (
    input  logic                     m00_axis_aclk,
    input  logic                     s00_axi_aresetn,
    input  udp_stream_pkg::hdr_cfg_t hdr_cfg,
    input  logic                     hdr_changed,
    output logic [15:0]              csum,
    output logic                     csum_ready
);

    localparam logic [15:0] IP_LEN = 16'(28 + 2 * `UDP_PAYLOAD_HALFWORDS);

    logic [3:0] step;  // 0..9 halfwords, 10 fold, 11 invert, 12 done
    logic [3:0] idx;
    logic [15:0] hw;
    logic [19:0] sum;  // Ten halfwords fit in 20 bits
    logic sum_done;

    assign idx = hdr_changed ? 4'd0 : step; // Change restarts at halfword 0
    assign csum_ready = sum_done && !hdr_changed;

    always_comb begin
        case (idx)
            4'd0:    hw = 16'h4500;
            4'd1:    hw = IP_LEN;
            4'd2:    hw = 16'h0001; // Identification
            4'd3:    hw = 16'h4000; // Don't fragment
            4'd4:    hw = 16'hFF11; // TTL 255, UDP
            4'd6:    hw = hdr_cfg.src_ip[31:16];
            4'd7:    hw = hdr_cfg.src_ip[15:0];
            4'd8:    hw = hdr_cfg.dst_ip[31:16];
            4'd9:    hw = hdr_cfg.dst_ip[15:0];
            default: hw = 16'h0000; // Checksum field itself counts as zero
        endcase
    end

    always_ff @(posedge m00_axis_aclk or negedge s00_axi_aresetn) begin
        if (!s00_axi_aresetn) begin
            step     <= 4'd0;
            sum_done <= 1'b0;
        end else if (hdr_changed) begin
            step     <= 4'd1;
            sum_done <= 1'b0;
        end else if (step != 4'd12) begin
            step     <= step + 4'd1;
            sum_done <= (step == 4'd11);
        end
    end

    always_ff @(posedge m00_axis_aclk) begin
        if (idx == 4'd0) sum <= {4'd0, hw};
        else if (idx < 4'd10) sum <= sum + {4'd0, hw};
        else if (idx == 4'd10) sum <= {4'd0, sum[15:0]} + {16'd0, sum[19:16]};
        else if (idx == 4'd11) csum <= ~(sum[15:0] + {15'd0, sum[16]}); // Last carry folded here
    end

endmodule

`default_nettype wire

// File: source/send_timer.sv
`timescale 1ns/1ps
`default_nettype none

module send_timer (
    input  logic        m00_axis_aclk,
    input  logic        s00_axi_aresetn,
    input  logic [31:0] packet_delay,
    input  logic        delay_written,
    output logic        send_trigger
);

    logic [31:0] count;

    always_ff @(posedge m00_axis_aclk or negedge s00_axi_aresetn) begin
        if (!s00_axi_aresetn) begin
            count        <= 32'd0;
            send_trigger <= 1'b0;
        end else if (delay_written) begin
            count        <= 32'd0; // New period starts from scratch
            send_trigger <= 1'b0;
        end else if ((packet_delay != 32'd0) && (count == packet_delay)) begin
            count        <= 32'd0;
            send_trigger <= 1'b1;
        end else begin
            count        <= count + 32'd1;
            send_trigger <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: source/udp_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "udp_stream_cfg.svh"

module udp_regs (
    input  logic                            m00_axis_aclk,
    input  logic                            s00_axi_aresetn,
    input  logic                            reg_wr,
    input  logic                            reg_rd,
    input  logic [`UDP_REG_ADDR_W-1:0]      reg_addr,
    input  udp_stream_pkg::reg_word_u       reg_wdata,
    input  logic [31:0]                     sent_count,
    input  logic                            busy,
    output logic [`UDP_REG_W-1:0]           rd_data,
    output logic                            rd_valid,
    output udp_stream_pkg::hdr_cfg_t        hdr_cfg,
    output logic [31:0]                     packet_delay,
    output logic                            hdr_changed,
    output logic                            delay_written
);

    logic [31:0] mac_stage; // MAC bytes 2..5 waiting for the high half
    logic hdr_write;

    assign hdr_write = reg_wr && (reg_addr inside {`UDP_ADDR_DMAC_HI, `UDP_ADDR_SIP,
                                                   `UDP_ADDR_DIP, `UDP_ADDR_SPORT,
                                                   `UDP_ADDR_DPORT});

    assign delay_written = reg_wr && (reg_addr == `UDP_ADDR_DELAY); // Timer restart

    always_ff @(posedge m00_axis_aclk or negedge s00_axi_aresetn) begin
        if (!s00_axi_aresetn) begin
            hdr_cfg.dst_mac  <= '1; // Broadcast
            hdr_cfg.src_ip   <= `UDP_DEFAULT_SIP;
            hdr_cfg.dst_ip   <= `UDP_DEFAULT_DIP;
            hdr_cfg.src_port <= `UDP_DEFAULT_PORT;
            hdr_cfg.dst_port <= `UDP_DEFAULT_PORT;
            packet_delay     <= `UDP_DEFAULT_DELAY;
            mac_stage        <= '1;
            hdr_changed      <= 1'b0;
        end else begin
            hdr_changed <= hdr_write;
            if (reg_wr) begin
                case (reg_addr)
                    `UDP_ADDR_DELAY:   packet_delay <= reg_wdata;
                    `UDP_ADDR_DMAC_LO: mac_stage <= reg_wdata.addr;
                    // High half commits the whole MAC in one go
                    `UDP_ADDR_DMAC_HI: hdr_cfg.dst_mac <= {reg_wdata.half.low, mac_stage};
                    `UDP_ADDR_SIP:     hdr_cfg.src_ip <= reg_wdata.addr;
                    `UDP_ADDR_DIP:     hdr_cfg.dst_ip <= reg_wdata.addr;
                    `UDP_ADDR_SPORT:   hdr_cfg.src_port <= reg_wdata.half.low;
                    `UDP_ADDR_DPORT:   hdr_cfg.dst_port <= reg_wdata.half.low;
                    default: ;
                endcase
            end
        end
    end

    // Read data lands one cycle after the strobe
    always_ff @(posedge m00_axis_aclk or negedge s00_axi_aresetn) begin
        if (!s00_axi_aresetn) begin
            rd_data  <= '0;
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= reg_rd;
            if (reg_rd) begin
                case (reg_addr)
                    `UDP_ADDR_SENT:    rd_data <= sent_count;
                    `UDP_ADDR_STATUS:  rd_data <= {31'd0, busy};
                    `UDP_ADDR_DELAY:   rd_data <= packet_delay;
                    `UDP_ADDR_DMAC_LO: rd_data <= hdr_cfg.dst_mac[31:0];
                    `UDP_ADDR_DMAC_HI: rd_data <= {16'd0, hdr_cfg.dst_mac[47:32]};
                    `UDP_ADDR_SIP:     rd_data <= hdr_cfg.src_ip;
                    `UDP_ADDR_DIP:     rd_data <= hdr_cfg.dst_ip;
                    `UDP_ADDR_SPORT:   rd_data <= {16'd0, hdr_cfg.src_port};
                    `UDP_ADDR_DPORT:   rd_data <= {16'd0, hdr_cfg.dst_port};
                    default:           rd_data <= '0;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: source/udp_stream_pkg.sv
`default_nettype none

`include "udp_stream_cfg.svh"

package udp_stream_pkg;

    // Programmable part of the frame header
    typedef struct packed {
        logic [47:0] dst_mac;
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [15:0] src_port;
        logic [15:0] dst_port;
    } hdr_cfg_t;

    // Register write word, seen either as bytes or as a 16-bit field
    typedef union packed {
        logic [0:3][7:0] addr; // addr[0] is the most significant byte
        struct packed {
            logic [15:0] unused;
            logic [15:0] low;
        } half;
    } reg_word_u;

    // One stream beat
    typedef struct packed {
        logic [`UDP_DATA_W-1:0] tdata;
        logic [`UDP_KEEP_W-1:0] tkeep;
        logic tlast;
    } axis_beat_t;

    // Test pattern 0, 255, 1, 254, 2, 253 ...
    function automatic logic [15:0] payload_half(input int unsigned j);
        if (j[0] == 1'b0) begin
            return 16'(j >> 1); // Even halfwords count up
        end else begin
            return 16'(255 - ((j - 1) >> 1)); // Odd ones count down from 255
        end
    endfunction

endpackage

`default_nettype wire

// File: source/udp_stream_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "udp_stream_cfg.svh"

module udp_stream_top (
    input  logic                       m00_axis_aclk,
    input  logic                       s00_axi_aresetn,
    input  logic                       reg_wr,
    input  logic                       reg_rd,
    input  logic [`UDP_REG_ADDR_W-1:0] reg_addr,
    input  udp_stream_pkg::reg_word_u  reg_wdata,
    output logic [`UDP_REG_W-1:0]      rd_data,
    output logic                       rd_valid,
    output udp_stream_pkg::axis_beat_t stream,
    output logic                       tvalid,
    input  logic                       tready
);

    import udp_stream_pkg::*;

    hdr_cfg_t hdr_cfg;
    logic [31:0] packet_delay;
    logic hdr_changed;
    logic delay_written;
    logic [15:0] csum;
    logic csum_ready;
    logic send_trigger;
    logic [31:0] sent_count;
    logic busy;

    udp_regs regs_i (
        .m00_axis_aclk, .s00_axi_aresetn,
        .reg_wr, .reg_rd, .reg_addr, .reg_wdata,
        .sent_count, .busy,
        .rd_data, .rd_valid,
        .hdr_cfg, .packet_delay, .hdr_changed, .delay_written
    );

    ip_checksum csum_i (
        .m00_axis_aclk, .s00_axi_aresetn,
        .hdr_cfg, .hdr_changed,
        .csum, .csum_ready
    );

    send_timer timer_i (
        .m00_axis_aclk, .s00_axi_aresetn,
        .packet_delay, .delay_written,
        .send_trigger
    );

    frame_sender sender_i (
        .m00_axis_aclk, .s00_axi_aresetn,
        .send_trigger, .csum_ready, .hdr_cfg, .csum, .tready,
        .stream, .tvalid, .busy, .sent_count
    );

endmodule

`default_nettype wire

// File: test/udp_stream_checker.sv
`timescale 1ns/1ps
`default_nettype none

module udp_stream_checker (
    input logic                       m00_axis_aclk,
    input logic                       s00_axi_aresetn,
    input udp_stream_pkg::axis_beat_t stream,
    input logic                       tvalid,
    input logic                       tready,
    input logic                       rd_valid
);

    int unsigned fails = 0;

    // A stalled beat stays put
    hold_when_stalled: assert property (@(posedge m00_axis_aclk) disable iff (!s00_axi_aresetn)
        tvalid && !tready |=> tvalid && $stable(stream))
        else begin
            fails++;
            $error("stream beat changed while tready was low");
        end

    last_needs_valid: assert property (@(posedge m00_axis_aclk) disable iff (!s00_axi_aresetn)
        stream.tlast |-> tvalid)
        else begin
            fails++;
            $error("tlast seen without tvalid");
        end

    keep_not_empty: assert property (@(posedge m00_axis_aclk) disable iff (!s00_axi_aresetn)
        tvalid |-> stream.tkeep != '0)
        else begin
            fails++;
            $error("valid beat with empty tkeep");
        end

    single_read_pulse: assert property (@(posedge m00_axis_aclk) disable iff (!s00_axi_aresetn)
        rd_valid |=> !rd_valid)
        else begin
            fails++;
            $error("rd_valid high for two cycles");
        end

endmodule

bind udp_stream_top udp_stream_checker checker_i (
    .m00_axis_aclk, .s00_axi_aresetn, .stream, .tvalid, .tready, .rd_valid
);

`default_nettype wire

// File: test/udp_stream_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "udp_stream_cfg.svh"

module udp_stream_tb;

    import udp_stream_pkg::*;

    localparam int TEST_DELAY = 40;
    localparam int FRAME_CYCLES = TEST_DELAY + 1 + 2 * `UDP_BEATS; // Period plus a stalled frame
    // Six tests of register traffic, six frames and the idle window, doubled
    localparam int TIMEOUT_CYCLES = 2 * (6 * 60 + 6 * FRAME_CYCLES + 200);
    localparam logic [15:0] IP_LEN = 16'(28 + 2 * `UDP_PAYLOAD_HALFWORDS);
    localparam logic [15:0] UDP_LEN = 16'(8 + 2 * `UDP_PAYLOAD_HALFWORDS);

    logic m00_axis_aclk;
    logic s00_axi_aresetn;
    logic reg_wr;
    logic reg_rd;
    logic [`UDP_REG_ADDR_W-1:0] reg_addr;
    reg_word_u reg_wdata;
    logic [`UDP_REG_W-1:0] rd_data;
    logic rd_valid;
    axis_beat_t stream;
    logic tvalid;
    logic tready;

    hdr_cfg_t exp_cfg;     // Header the monitor expects
    integer seed = 28;
    int ready_mode = 0;    // 0 high, 1 random, 2 low
    int errors = 0;
    int checks = 0;
    int frames_seen = 0;
    int mon_beat = 0;
    int test_num = 0;
    int test_base = 0;
    int cycle_count = 0;

    udp_stream_top dut_i (.*);

    initial begin
        m00_axis_aclk = 1'b0;
        forever #2 m00_axis_aclk = ~m00_axis_aclk;
    end

    initial begin
        int rnd;
        tready = 1'b1;
        forever begin
            @(posedge m00_axis_aclk);
            #1;
            rnd = $random(seed);
            tready = (ready_mode == 0) || (ready_mode == 1 && rnd[0]);
        end
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge m00_axis_aclk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("test failed");
        $finish;
    end

    // Ones-complement sum of the ten IPv4 header halfwords
    function automatic logic [15:0] ref_csum(input hdr_cfg_t cfg);
        logic [31:0] acc;
        acc = 32'h4500 + IP_LEN + 32'h0001 + 32'h4000 + 32'hFF11 + cfg.src_ip[31:16]
            + cfg.src_ip[15:0] + cfg.dst_ip[31:16] + cfg.dst_ip[15:0];
        while (acc[31:16] != 16'd0)
            acc = {16'd0, acc[15:0]} + {16'd0, acc[31:16]};
        return ~acc[15:0];
    endfunction

    function automatic logic [7:0] frame_byte(input int i, input hdr_cfg_t cfg);
        logic [42*8-1:0] hdr;
        logic [15:0] half;
        hdr = {cfg.dst_mac, `UDP_SRC_MAC, 16'h0800, 16'h4500, IP_LEN, 16'h0001, 16'h4000,
               16'hFF11, ref_csum(cfg), cfg.src_ip, cfg.dst_ip, cfg.src_port, cfg.dst_port,
               UDP_LEN, 16'h0000};
        if (i < 42) return hdr[8 * (41 - i) +: 8];
        half = payload_half((i - 42) / 2);
        return (i % 2 == 0) ? half[7:0] : half[15:8]; // Low byte at even offsets
    endfunction

    function automatic axis_beat_t ref_beat(input int b, input hdr_cfg_t cfg);
        axis_beat_t beat;
        beat = '0;
        for (int k = 0; k < `UDP_KEEP_W; k++) begin
            if (8 * b + k < `UDP_FRAME_BYTES) begin
                beat.tdata[8 * k +: 8] = frame_byte(8 * b + k, cfg);
                beat.tkeep[k] = 1'b1;
            end
        end
        beat.tlast = (b == `UDP_BEATS - 1);
        return beat;
    endfunction

    task automatic check_beat(input axis_beat_t got, input axis_beat_t exp, input int b);
        logic [`UDP_DATA_W-1:0] mask;
        for (int k = 0; k < `UDP_KEEP_W; k++) mask[8 * k +: 8] = {8{exp.tkeep[k]}};
        checks++;
        if ((got.tdata & mask) !== exp.tdata || got.tkeep !== exp.tkeep
                || got.tlast !== exp.tlast) begin
            errors++;
            $display("MISMATCH at %0t: frame %0d beat %0d got data %h keep %h last %b",
                     $time, frames_seen, b, got.tdata, got.tkeep, got.tlast);
            $display("    expected data %h keep %h last %b", exp.tdata, exp.tkeep, exp.tlast);
        end
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s read 0x%08h, expected 0x%08h", $time, what, got, exp);
        end
    endtask

    // Accepted beats, sampled half a cycle away from any change
    always @(negedge m00_axis_aclk) begin
        if (s00_axi_aresetn && tvalid && tready) begin
            check_beat(stream, ref_beat(mon_beat, exp_cfg), mon_beat);
            if (stream.tlast) begin
                frames_seen++;
                mon_beat = 0;
            end else begin
                mon_beat++;
            end
        end
    end

    task automatic reg_write(input logic [`UDP_REG_ADDR_W-1:0] addr, input logic [31:0] data);
        @(posedge m00_axis_aclk);
        #1;
        reg_wr = 1'b1;
        reg_addr = addr;
        reg_wdata = data;
        @(posedge m00_axis_aclk);
        #1;
        reg_wr = 1'b0;
    endtask

    task automatic check_reg(input logic [`UDP_REG_ADDR_W-1:0] addr, input logic [31:0] exp,
                             input string what);
        int waited;
        waited = 0;
        @(posedge m00_axis_aclk);
        #1;
        reg_rd = 1'b1;
        reg_addr = addr;
        @(posedge m00_axis_aclk);
        #1;
        reg_rd = 1'b0;
        @(negedge m00_axis_aclk);
        while (!rd_valid && waited < 8) begin
            @(negedge m00_axis_aclk);
            waited++;
        end
        if (!rd_valid) begin
            errors++;
            $display("No read response came back for %s", what);
        end else begin
            check_word(rd_data, exp, what);
        end
    endtask

    task automatic write_header(input hdr_cfg_t cfg);
        reg_write(`UDP_ADDR_DMAC_LO, cfg.dst_mac[31:0]);
        reg_write(`UDP_ADDR_DMAC_HI, {16'd0, cfg.dst_mac[47:32]});
        reg_write(`UDP_ADDR_SIP, cfg.src_ip);
        reg_write(`UDP_ADDR_DIP, cfg.dst_ip);
        reg_write(`UDP_ADDR_SPORT, {16'd0, cfg.src_port});
        reg_write(`UDP_ADDR_DPORT, {16'd0, cfg.dst_port});
    endtask

    task automatic wait_frames(input int count);
        int target;
        int waited;
        target = frames_seen + count;
        waited = 0;
        while (frames_seen < target && waited < 2 * count * FRAME_CYCLES) begin
            @(posedge m00_axis_aclk);
            waited++;
        end
        if (frames_seen < target) begin
            errors++;
            $display("Expected frames did not arrive within %0d cycles", waited);
        end
    endtask

    // Timer off, then let a frame in flight drain
    task automatic stop_frames();
        int waited;
        waited = 0;
        reg_write(`UDP_ADDR_DELAY, 32'd0);
        @(negedge m00_axis_aclk);
        while (tvalid && waited < FRAME_CYCLES) begin
            @(negedge m00_axis_aclk);
            waited++;
        end
        if (tvalid) begin
            errors++;
            $display("A frame did not finish after the timer was stopped");
        end
    endtask

    task automatic end_test(input string name);
        test_num++;
        $display("Test %0d %s: %0d errors", test_num, name, errors - test_base);
        test_base = errors;
    endtask

    initial begin
        hdr_cfg_t dflt;
        hdr_cfg_t next;
        int waited;
        int busy_cycles;
        reg_wr = 1'b0;
        reg_rd = 1'b0;
        reg_addr = '0;
        reg_wdata = '0;
        s00_axi_aresetn = 1'b0;
        dflt = '{dst_mac: 48'hFFFF_FFFF_FFFF, src_ip: `UDP_DEFAULT_SIP, dst_ip: `UDP_DEFAULT_DIP,
                 src_port: `UDP_DEFAULT_PORT, dst_port: `UDP_DEFAULT_PORT};
        next = '{dst_mac: 48'h0102_0A0B_0C0D, src_ip: 32'hAC10_0005, dst_ip: 32'hAC10_00FE,
                 src_port: 16'd1234, dst_port: 16'd5001};
        exp_cfg = dflt;
        repeat (5) @(posedge m00_axis_aclk);
        #1;
        s00_axi_aresetn = 1'b1;

        check_reg(`UDP_ADDR_DELAY, `UDP_DEFAULT_DELAY, "DELAY after reset");
        check_reg(`UDP_ADDR_DMAC_LO, 32'hFFFF_FFFF, "DMAC_LO after reset");
        check_reg(`UDP_ADDR_DMAC_HI, 32'h0000_FFFF, "DMAC_HI after reset");
        check_reg(`UDP_ADDR_SIP, `UDP_DEFAULT_SIP, "SIP after reset");
        check_reg(`UDP_ADDR_DIP, `UDP_DEFAULT_DIP, "DIP after reset");
        check_reg(`UDP_ADDR_SPORT, {16'd0, `UDP_DEFAULT_PORT}, "SPORT after reset");
        check_reg(`UDP_ADDR_DPORT, {16'd0, `UDP_DEFAULT_PORT}, "DPORT after reset");
        check_reg(`UDP_ADDR_SENT, 32'd0, "SENT after reset");
        check_reg(`UDP_ADDR_STATUS, 32'd0, "STATUS after reset");
        end_test("reset values");

        reg_write(`UDP_ADDR_DMAC_LO, 32'h3344_5566); // Staged only
        check_reg(`UDP_ADDR_DMAC_LO, 32'hFFFF_FFFF, "DMAC_LO before commit");
        check_reg(`UDP_ADDR_DMAC_HI, 32'h0000_FFFF, "DMAC_HI before commit");
        reg_write(`UDP_ADDR_DMAC_HI, 32'hABCD_1122);
        check_reg(`UDP_ADDR_DMAC_LO, 32'h3344_5566, "DMAC_LO after commit");
        check_reg(`UDP_ADDR_DMAC_HI, 32'h0000_1122, "DMAC_HI after commit");
        reg_write(`UDP_ADDR_SIP, 32'h0A00_0001);
        reg_write(`UDP_ADDR_DIP, 32'h0A00_0002);
        reg_write(`UDP_ADDR_SPORT, 32'hBEEF_1234); // Upper half is dropped
        reg_write(`UDP_ADDR_DPORT, 32'h0000_5678);
        check_reg(`UDP_ADDR_SIP, 32'h0A00_0001, "SIP readback");
        check_reg(`UDP_ADDR_DIP, 32'h0A00_0002, "DIP readback");
        check_reg(`UDP_ADDR_SPORT, 32'h0000_1234, "SPORT readback");
        check_reg(`UDP_ADDR_DPORT, 32'h0000_5678, "DPORT readback");
        check_reg(6'h24, 32'd0, "unknown address 0x24");
        write_header(dflt);
        end_test("register access");

        reg_write(`UDP_ADDR_DELAY, TEST_DELAY);
        wait_frames(1);
        stop_frames();
        end_test("default frame");

        write_header(next);
        exp_cfg = next;
        reg_write(`UDP_ADDR_DELAY, TEST_DELAY);
        wait_frames(1);
        stop_frames();
        end_test("new header");

        ready_mode = 1;
        reg_write(`UDP_ADDR_DELAY, TEST_DELAY);
        wait_frames(2);
        stop_frames();
        ready_mode = 0;
        end_test("random tready");

        ready_mode = 2; // Hold the next frame at its first beat
        reg_write(`UDP_ADDR_DELAY, TEST_DELAY);
        waited = 0;
        while (!tvalid && waited < 2 * FRAME_CYCLES) begin
            @(negedge m00_axis_aclk);
            waited++;
        end
        check_reg(`UDP_ADDR_STATUS, 32'd1, "STATUS mid-frame");
        ready_mode = 0;
        stop_frames();
        busy_cycles = 0;
        repeat (200) begin
            @(negedge m00_axis_aclk);
            if (tvalid) busy_cycles++;
        end
        if (busy_cycles != 0) begin
            errors++;
            $display("A frame started although DELAY was set to zero");
        end
        check_reg(`UDP_ADDR_STATUS, 32'd0, "STATUS when idle");
        check_reg(`UDP_ADDR_SENT, frames_seen, "SENT against frames received");
        end_test("count, status and stop");

        $display("Summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
                 test_num, checks, errors, dut_i.checker_i.fails);
        if (errors == 0 && dut_i.checker_i.fails == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
